// File: logic/cpu_params.svh
/*
 * width and depth settings for the rename/retire front end
 * include this wherever the sizes are needed
 * the package builds its vector types from these values
 */

`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// superscalar width, instructions per cycle
`define N 2

// architectural and physical register file sizes
`define ARCH_REGS 8
`define PHYS_REGS 16

// reorder buffer entries
`define ROB_SZ 8

// instruction buffer entries
`define IB_SZ 8

`endif

// File: logic/cpu_pkg.sv
/*
 * vector types shared by the RTL and the testbench
 * widths come from the params header
 * modules import this inside their body and use scoped names on ports
 */

`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

    ////////////////////////////////////////////////////////////
    // register indices
    ////////////////////////////////////////////////////////////

    // architectural register number
    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;

    // physical register number, also the completion tag
    typedef logic [$clog2(`PHYS_REGS)-1:0] phys_reg_t;

    ////////////////////////////////////////////////////////////
    // queue bookkeeping
    ////////////////////////////////////////////////////////////

    // slot in the reorder buffer
    typedef logic [$clog2(`ROB_SZ)-1:0] rob_idx_t;

    // per-cycle instruction count, 0 up to N
    typedef logic [$clog2(`N+1)-1:0] count_t;

    // occupancy or open entries, 0 up to 8
    typedef logic [$clog2(`IB_SZ+1)-1:0] occ_t;

    // fetch byte address
    typedef logic [31:0] addr_t;

endpackage

`default_nettype wire

// File: logic/inst_buffer.sv
/*
 * circular instruction queue in front of rename
 * takes up to N instructions per cycle, limited by its open entries
 * the head entries are shown combinationally for dispatch
 * release_count removes the dispatched ones at the next edge
 */

`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module inst_buffer (
    input  logic                              clock,
    input  logic                              reset,
    input  cpu_pkg::count_t                   in_count,
    input  cpu_pkg::arch_reg_t [`N-1:0]       in_dest,
    input  cpu_pkg::count_t                   release_count,
    output cpu_pkg::count_t                   accept_count,
    output cpu_pkg::count_t                   ib_count,
    output cpu_pkg::arch_reg_t [`N-1:0]       ib_dest,
    output cpu_pkg::occ_t                     open_entries
);
    import cpu_pkg::*;

    localparam int PTR_W = $clog2(`IB_SZ);

    // payload storage, one dest per entry
    arch_reg_t mem [`IB_SZ];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    occ_t             occupancy;

    ////////////////////////////////////////////////////////////
    // counts
    ////////////////////////////////////////////////////////////

    assign open_entries = occ_t'(`IB_SZ) - occupancy;

    // take what fits
    always_comb begin
        if (occ_t'(in_count) <= open_entries) begin
            accept_count = in_count;
        end else begin
            // open_entries is below N here so it fits
            accept_count = count_t'(open_entries);
        end
    end

    // visible head entries, capped at N
    assign ib_count = (occupancy >= occ_t'(`N)) ? count_t'(`N) : count_t'(occupancy);

    // head window, older entry in slot 0
    always_comb begin
        for (int i = 0; i < `N; i++) begin
            ib_dest[i] = mem[head + PTR_W'(i)];
        end
    end

    ////////////////////////////////////////////////////////////
    // pointers and storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end else begin
            head      <= head + PTR_W'(release_count);
            tail      <= tail + PTR_W'(accept_count);
            occupancy <= occupancy + occ_t'(accept_count) - occ_t'(release_count);
        end
    end

    // accepted dests land after the tail in slot order
    always_ff @(posedge clock) begin
        for (int i = 0; i < `N; i++) begin
            if (i < accept_count) begin
                mem[tail + PTR_W'(i)] <= in_dest[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/map_table.sv
/*
 * architectural to physical register map
 * returns the previous mapping of each renamed dest
 * slot 1 sees slot 0's new mapping when both rename the same dest
 */

`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module map_table (
    input  logic                              clock,
    input  logic                              reset,
    input  cpu_pkg::count_t                   rename_count,
    input  cpu_pkg::arch_reg_t [`N-1:0]       rename_dest,
    input  cpu_pkg::phys_reg_t [`N-1:0]       new_phys,
    output cpu_pkg::phys_reg_t [`N-1:0]       t_old
);
    import cpu_pkg::*;

    // one phys reg per arch reg
    phys_reg_t map [`ARCH_REGS];

    // old mappings, with same-group bypass
    always_comb begin
        t_old[0] = map[rename_dest[0]];
        t_old[1] = map[rename_dest[1]];
        if (rename_count != '0 && rename_dest[1] == rename_dest[0]) begin
            // slot 0 overwrites this dest first
            t_old[1] = new_phys[0];
        end
    end

    // identity after reset, slot 1 last so it wins a collision
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < `ARCH_REGS; a++) begin
                map[a] <= phys_reg_t'(a);
            end
        end else begin
            for (int i = 0; i < `N; i++) begin
                if (i < rename_count) begin
                    map[rename_dest[i]] <= new_phys[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/free_list.sv
/*
 * FIFO of free physical registers
 * dispatch pops from the head, retirement pushes old tags at the tail
 * the two head entries are always visible for rename
 * after reset it holds the regs above the identity map, in ascending order
 */

`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module free_list (
    input  logic                              clock,
    input  logic                              reset,
    input  cpu_pkg::count_t                   pop_count,
    input  cpu_pkg::count_t                   push_count,
    input  cpu_pkg::phys_reg_t [`N-1:0]       push_reg,
    output cpu_pkg::phys_reg_t [`N-1:0]       free_reg,
    output cpu_pkg::occ_t                     free_count
);
    import cpu_pkg::*;

    localparam int PTR_W  = $clog2(`PHYS_REGS);
    localparam int N_FREE = `PHYS_REGS - `ARCH_REGS;

    phys_reg_t        mem [`PHYS_REGS];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;

    // head window for the next rename group
    always_comb begin
        for (int i = 0; i < `N; i++) begin
            free_reg[i] = mem[head + PTR_W'(i)];
        end
    end

    ////////////////////////////////////////////////////////////
    // pop, push and count
    ////////////////////////////////////////////////////////////

    // at most 8 regs are free, so head and tail never collide
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < N_FREE; i++) begin
                mem[i] <= phys_reg_t'(`ARCH_REGS + i);
            end
            head       <= '0;
            tail       <= PTR_W'(N_FREE);
            free_count <= occ_t'(N_FREE);
        end else begin
            // pushes in slot order after the tail
            for (int i = 0; i < `N; i++) begin
                if (i < push_count) begin
                    mem[tail + PTR_W'(i)] <= push_reg[i];
                end
            end
            head       <= head + PTR_W'(pop_count);
            tail       <= tail + PTR_W'(push_count);
            free_count <= free_count + occ_t'(push_count) - occ_t'(pop_count);
        end
    end

endmodule

`default_nettype wire

// File: logic/rob.sv
/*
 * reorder buffer for renamed instructions
 * each entry keeps dest, t and t_old plus valid and complete bits
 * completion tags mark matching valid entries complete
 * up to N leading complete entries retire in order from the head
 */

`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module rob (
    input  logic                              clock,
    input  logic                              reset,
    input  cpu_pkg::count_t                   alloc_count,
    input  cpu_pkg::arch_reg_t [`N-1:0]       alloc_dest,
    input  cpu_pkg::phys_reg_t [`N-1:0]       alloc_t,
    input  cpu_pkg::phys_reg_t [`N-1:0]       alloc_t_old,
    input  logic [`N-1:0]                     complete_valid,
    input  cpu_pkg::phys_reg_t [`N-1:0]       complete_tag,
    output cpu_pkg::occ_t                     open_entries,
    output cpu_pkg::count_t                   retire_count,
    output cpu_pkg::arch_reg_t [`N-1:0]       retire_dest,
    output cpu_pkg::phys_reg_t [`N-1:0]       retire_t,
    output cpu_pkg::phys_reg_t [`N-1:0]       retire_t_old
);
    import cpu_pkg::*;

    // entry payload
    arch_reg_t entry_dest  [`ROB_SZ];
    phys_reg_t entry_t     [`ROB_SZ];
    phys_reg_t entry_t_old [`ROB_SZ];

    // entry status
    logic [`ROB_SZ-1:0] valid;
    logic [`ROB_SZ-1:0] complete;

    rob_idx_t head;
    rob_idx_t tail;
    occ_t     occupancy;

    assign open_entries = occ_t'(`ROB_SZ) - occupancy;

    ////////////////////////////////////////////////////////////
    // retire window
    ////////////////////////////////////////////////////////////

    // count leading ready entries, stop at the first gap
    always_comb begin
        retire_count = '0;
        for (int i = 0; i < `N; i++) begin
            if (valid[head + rob_idx_t'(i)] && complete[head + rob_idx_t'(i)]
                && retire_count == count_t'(i)) begin
                retire_count = count_t'(i + 1);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `N; i++) begin
            retire_dest[i]  = entry_dest[head + rob_idx_t'(i)];
            retire_t[i]     = entry_t[head + rob_idx_t'(i)];
            retire_t_old[i] = entry_t_old[head + rob_idx_t'(i)];
        end
    end

    ////////////////////////////////////////////////////////////
    // status update
    ////////////////////////////////////////////////////////////

    // alloc slots are free now, retiring ones are valid, so they never overlap
    always_ff @(posedge clock) begin
        if (reset) begin
            valid     <= '0;
            complete  <= '0;
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end else begin
            // tag match on live entries
            for (int e = 0; e < `ROB_SZ; e++) begin
                for (int j = 0; j < `N; j++) begin
                    if (complete_valid[j] && valid[e] && entry_t[e] == complete_tag[j]) begin
                        complete[e] <= 1'b1;
                    end
                end
            end
            for (int i = 0; i < `N; i++) begin
                if (i < retire_count) begin
                    valid[head + rob_idx_t'(i)]    <= 1'b0;
                    complete[head + rob_idx_t'(i)] <= 1'b0;
                end
                if (i < alloc_count) begin
                    valid[tail + rob_idx_t'(i)]    <= 1'b1;
                    complete[tail + rob_idx_t'(i)] <= 1'b0;
                end
            end
            head      <= head + rob_idx_t'(retire_count);
            tail      <= tail + rob_idx_t'(alloc_count);
            occupancy <= occupancy + occ_t'(alloc_count) - occ_t'(retire_count);
        end
    end

    // payload written at allocation only
    always_ff @(posedge clock) begin
        for (int i = 0; i < `N; i++) begin
            if (i < alloc_count) begin
                entry_dest[tail + rob_idx_t'(i)]  <= alloc_dest[i];
                entry_t[tail + rob_idx_t'(i)]     <= alloc_t[i];
                entry_t_old[tail + rob_idx_t'(i)] <= alloc_t_old[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu.sv
/*
 * top level of the rename and retire front end
 * fetch PC, instruction buffer, map table, free list and reorder buffer
 * completions arrive as phys tags, commits leave from the ROB head
 */

`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu (
    input  logic                              clock,
    input  logic                              reset,
    input  cpu_pkg::count_t                   in_count,
    input  cpu_pkg::arch_reg_t [`N-1:0]       in_dest,
    input  logic [`N-1:0]                     complete_valid,
    input  cpu_pkg::phys_reg_t [`N-1:0]       complete_tag,
    output cpu_pkg::addr_t                    pc,
    output cpu_pkg::occ_t                     ib_open,
    output cpu_pkg::count_t                   commit_count,
    output cpu_pkg::arch_reg_t [`N-1:0]       commit_dest,
    output cpu_pkg::phys_reg_t [`N-1:0]       commit_t,
    output cpu_pkg::phys_reg_t [`N-1:0]       commit_t_old
);
    import cpu_pkg::*;

    count_t                 accept_count;
    count_t                 ib_count;
    arch_reg_t [`N-1:0]     ib_dest;
    count_t                 dispatch_count;
    phys_reg_t [`N-1:0]     free_reg;
    phys_reg_t [`N-1:0]     t_old;
    occ_t                   free_count;
    occ_t                   rob_open;

    ////////////////////////////////////////////////////////////
    // fetch pc, four bytes per accepted instruction
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc + (addr_t'(accept_count) << 2);
        end
    end

    ////////////////////////////////////////////////////////////
    // dispatch count
    ////////////////////////////////////////////////////////////

    // ib_count is already capped at N
    always_comb begin
        dispatch_count = ib_count;
        if (occ_t'(dispatch_count) > rob_open) begin
            dispatch_count = count_t'(rob_open);
        end
        if (occ_t'(dispatch_count) > free_count) begin
            dispatch_count = count_t'(free_count);
        end
    end

    inst_buffer u_inst_buffer (
        .clock         (clock),
        .reset         (reset),
        .in_count      (in_count),
        .in_dest       (in_dest),
        .release_count (dispatch_count),
        .accept_count  (accept_count),
        .ib_count      (ib_count),
        .ib_dest       (ib_dest),
        .open_entries  (ib_open)
    );

    // rename, new tags straight from the free list head
    map_table u_map_table (
        .clock        (clock),
        .reset        (reset),
        .rename_count (dispatch_count),
        .rename_dest  (ib_dest),
        .new_phys     (free_reg),
        .t_old        (t_old)
    );

    // retiring t_old values return at the same edge
    free_list u_free_list (
        .clock      (clock),
        .reset      (reset),
        .pop_count  (dispatch_count),
        .push_count (commit_count),
        .push_reg   (commit_t_old),
        .free_reg   (free_reg),
        .free_count (free_count)
    );

    rob u_rob (
        .clock          (clock),
        .reset          (reset),
        .alloc_count    (dispatch_count),
        .alloc_dest     (ib_dest),
        .alloc_t        (free_reg),
        .alloc_t_old    (t_old),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .open_entries   (rob_open),
        .retire_count   (commit_count),
        .retire_dest    (commit_dest),
        .retire_t       (commit_t),
        .retire_t_old   (commit_t_old)
    );

endmodule

`default_nettype wire

// File: tests/cpu_checker.sv
/*
 * bound assertions on the cpu top level
 * attached to every cpu instance by the testbench's bind
 */

`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu_checker (
    input logic            clock,
    input logic            reset,
    input cpu_pkg::addr_t  pc,
    input cpu_pkg::occ_t   ib_open,
    input cpu_pkg::count_t commit_count
);
    import cpu_pkg::*;

    // never more than the retire width
    commit_max: assert property (@(posedge clock) disable iff (reset)
        commit_count <= count_t'(`N))
        else $error("commit_count above the retire width");

    ib_open_max: assert property (@(posedge clock) disable iff (reset)
        ib_open <= occ_t'(`IB_SZ))
        else $error("ib_open above the buffer size");

    // four bytes per instruction
    pc_aligned: assert property (@(posedge clock) disable iff (reset)
        pc[1:0] == 2'b00)
        else $error("pc not word aligned");

    commit_after_reset: assert property (@(posedge clock)
        reset |=> commit_count == '0)
        else $error("commit_count nonzero right after reset");

endmodule

`default_nettype wire

// File: tests/cpu_tb.sv
/*
 * testbench for the rename and retire front end
 * a table of rows drives fetch and completion, one row per test
 * a cycle model predicts pc, ib_open and every commit
 * inputs change on the falling edge, outputs are checked there too
 */

`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int MAX_ROWS    = 16;
    localparam int DRAIN_LIMIT = 200;

    logic               clock;
    logic               reset;
    count_t             in_count;
    arch_reg_t [`N-1:0] in_dest;
    logic [`N-1:0]      complete_valid;
    phys_reg_t [`N-1:0] complete_tag;
    addr_t              pc;
    occ_t               ib_open;
    count_t             commit_count;
    arch_reg_t [`N-1:0] commit_dest;
    phys_reg_t [`N-1:0] commit_t;
    phys_reg_t [`N-1:0] commit_t_old;

    cpu dut (.*);

    bind cpu cpu_checker u_checker (
        .clock        (clock),
        .reset        (reset),
        .pc           (pc),
        .ib_open      (ib_open),
        .commit_count (commit_count)
    );

    // 8 ns period
    always #4 clock = ~clock;

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////

    string row_name     [MAX_ROWS];
    int    row_cycles   [MAX_ROWS];
    int    row_count    [MAX_ROWS];
    int    row_d0       [MAX_ROWS];
    int    row_d1       [MAX_ROWS];
    int    row_k        [MAX_ROWS];
    int    row_young    [MAX_ROWS];
    int    row_random   [MAX_ROWS];
    int    row_exp_open [MAX_ROWS];
    int    row_drain    [MAX_ROWS];
    int    n_rows;

    // exp_open of -1 means no ib_open check at the end of the row
    task add_row(input string name, input int cycles, cnt, d0, d1, k, young, rnd,
                 input int exp_open, drain);
        row_name[n_rows]     = name;
        row_cycles[n_rows]   = cycles;
        row_count[n_rows]    = cnt;
        row_d0[n_rows]       = d0;
        row_d1[n_rows]       = d1;
        row_k[n_rows]        = k;
        row_young[n_rows]    = young;
        row_random[n_rows]   = rnd;
        row_exp_open[n_rows] = exp_open;
        row_drain[n_rows]    = drain;
        n_rows++;
    endtask

    ////////////////////////////////////////////////////////////
    // reference model state
    ////////////////////////////////////////////////////////////

    int m_pc;
    int m_map [`ARCH_REGS];
    int ib_q [$];
    int free_q [$];
    int rob_dest [$];
    int rob_t [$];
    int rob_t_old [$];
    bit rob_done [$];
    int dispatched_total;
    int committed_total;
    int errors;

    logic [31:0] lfsr_state;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    task draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
    endtask

    task check_value(input string name, input logic [31:0] expected,
                     input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error at %0t: %s expected %0d actual %0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // identity map with phys 8..15 free
    task reset_model();
        m_pc = 0;
        ib_q.delete();
        free_q.delete();
        rob_dest.delete();
        rob_t.delete();
        rob_t_old.delete();
        rob_done.delete();
        for (int a = 0; a < `ARCH_REGS; a++) begin
            m_map[a] = a;
        end
        for (int p = `ARCH_REGS; p < `PHYS_REGS; p++) begin
            free_q.push_back(p);
        end
    endtask

    // leading complete entries up to N
    function automatic int model_commit_count();
        int c;
        c = 0;
        while (c < `N && c < rob_done.size() && rob_done[c]) begin
            c++;
        end
        return c;
    endfunction

    task check_outputs();
        int c;
        c = model_commit_count();
        check_value("pc", m_pc, pc);
        check_value("ib_open", `IB_SZ - ib_q.size(), ib_open);
        check_value("commit_count", c, commit_count);
        for (int i = 0; i < c; i++) begin
            check_value($sformatf("commit_dest[%0d]", i), rob_dest[i], commit_dest[i]);
            check_value($sformatf("commit_t[%0d]", i), rob_t[i], commit_t[i]);
            check_value($sformatf("commit_t_old[%0d]", i), rob_t_old[i], commit_t_old[i]);
        end
    endtask

    // k pending tags taken oldest or youngest first
    task choose_completions(input int k, input int young);
        int picked;
        int idx;
        complete_valid = '0;
        complete_tag   = '0;
        picked = 0;
        for (int n = 0; n < rob_done.size(); n++) begin
            idx = (young != 0) ? rob_done.size() - 1 - n : n;
            if (picked < k && !rob_done[idx]) begin
                complete_valid[picked] = 1'b1;
                complete_tag[picked]   = phys_reg_t'(rob_t[idx]);
                picked++;
            end
        end
    endtask

    // one rising edge worth of state change
    task step_model();
        int accept;
        int ib_cnt;
        int disp;
        int com;
        int d;
        int t;
        accept = int'(in_count);
        if (accept > `IB_SZ - ib_q.size()) begin
            accept = `IB_SZ - ib_q.size();
        end
        ib_cnt = (ib_q.size() < `N) ? ib_q.size() : `N;
        disp = ib_cnt;
        if (disp > `ROB_SZ - rob_t.size()) begin
            disp = `ROB_SZ - rob_t.size();
        end
        if (disp > free_q.size()) begin
            disp = free_q.size();
        end
        com = model_commit_count();
        // completions only see entries already in the ROB
        for (int e = 0; e < rob_t.size(); e++) begin
            for (int j = 0; j < `N; j++) begin
                if (complete_valid[j] && int'(complete_tag[j]) == rob_t[e]) begin
                    rob_done[e] = 1'b1;
                end
            end
        end
        // retiring old tags go back to the free list tail
        for (int i = 0; i < com; i++) begin
            free_q.push_back(rob_t_old[0]);
            void'(rob_dest.pop_front());
            void'(rob_t.pop_front());
            void'(rob_t_old.pop_front());
            void'(rob_done.pop_front());
        end
        // rename in slot order so a same-dest pair chains naturally
        for (int i = 0; i < disp; i++) begin
            d = ib_q.pop_front();
            t = free_q.pop_front();
            rob_dest.push_back(d);
            rob_t.push_back(t);
            rob_t_old.push_back(m_map[d]);
            rob_done.push_back(1'b0);
            m_map[d] = t;
            dispatched_total++;
        end
        for (int i = 0; i < accept; i++) begin
            ib_q.push_back(int'(in_dest[i]));
        end
        m_pc += 4 * accept;
    endtask

    // check and drive before stepping the model to the next falling edge
    task run_cycle(input int cnt, input int d0, input int d1, input int k, input int young);
        check_outputs();
        committed_total += int'(commit_count);
        in_count   = count_t'(cnt);
        in_dest[0] = arch_reg_t'(d0);
        in_dest[1] = arch_reg_t'(d1);
        choose_completions(k, young);
        step_model();
        @(negedge clock);
    endtask

    // complete everything without fetch until the DUT has committed all of it
    task drain(output bit timed_out);
        int waited;
        waited    = 0;
        timed_out = 1'b0;
        while (!timed_out && (ib_open != occ_t'(`IB_SZ)
                              || committed_total < dispatched_total)) begin
            run_cycle(0, 0, 0, 2, 0);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                timed_out = 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int  cnt;
        int  d0;
        int  d1;
        int  k;
        int  young;
        int  errors_before;
        int  tests_passed;
        int  tests_run;
        bit  timed_out;
        bit  aborted;

        clock            = 1'b0;
        reset            = 1'b1;
        in_count         = '0;
        in_dest          = '0;
        complete_valid   = '0;
        complete_tag     = '0;
        lfsr_state       = 32'h8526c104;
        errors           = 0;
        dispatched_total = 0;
        committed_total  = 0;
        tests_passed     = 0;
        tests_run        = 0;
        aborted          = 1'b0;
        n_rows           = 0;

        //      name                      cyc cnt d0 d1 k  yng rnd open drain
        add_row("reset and idle",           2, 0, 0, 0, 0, 0,  0,  8,   1);
        add_row("same-dest rename",         1, 2, 3, 3, 2, 0,  0, -1,   1);
        add_row("pc and ib_open",           6, 2, 1, 2, 2, 0,  0, -1,   1);
        add_row("rob and free list stall", 12, 2, 5, 6, 0, 0,  0,  0,   1);
        add_row("slow fetch stall",        11, 1, 7, 0, 0, 0,  0,  5,   0);
        add_row("partial accept",           3, 2, 2, 4, 0, 0,  0,  0,   1);
        add_row("out-of-order completion", 12, 2, 4, 5, 1, 1,  0, -1,   1);
        add_row("youngest-first pairs",    12, 2, 6, 6, 2, 1,  0, -1,   1);
        add_row("random run",             400, 0, 0, 0, 0, 0,  1, -1,   1);

        repeat (10) @(negedge clock);
        reset = 1'b0;
        reset_model();

        // reset state
        check_value("pc", 0, pc);
        check_value("ib_open", `IB_SZ, ib_open);
        check_value("commit_count", 0, commit_count);

        for (int r = 0; r < n_rows; r++) begin
            errors_before = errors;
            tests_run++;
            for (int c = 0; c < row_cycles[r]; c++) begin
                if (row_random[r] != 0) begin
                    draw_bits(2, cnt);
                    if (cnt > `N) begin
                        cnt = `N;
                    end
                    draw_bits(3, d0);
                    draw_bits(3, d1);
                    draw_bits(2, k);
                    if (k > `N) begin
                        k = `N;
                    end
                    draw_bits(1, young);
                end else begin
                    cnt   = row_count[r];
                    d0    = row_d0[r];
                    d1    = row_d1[r];
                    k     = row_k[r];
                    young = row_young[r];
                end
                run_cycle(cnt, d0, d1, k, young);
            end
            if (row_exp_open[r] >= 0) begin
                check_value("ib_open", row_exp_open[r], ib_open);
            end
            if (row_drain[r] != 0) begin
                drain(timed_out);
                if (timed_out) begin
                    $display("test %0d %s: drain did not finish in %0d cycles",
                             r, row_name[r], DRAIN_LIMIT);
                    aborted = 1'b1;
                    break;
                end
                check_value("committed total", dispatched_total, committed_total);
            end
            if (errors == errors_before) begin
                tests_passed++;
                $display("test %0d %s: ok", r, row_name[r]);
            end else begin
                $display("test %0d %s: %0d mismatches", r, row_name[r],
                         errors - errors_before);
            end
        end

        $display("passed %0d of %0d tests, %0d mismatches", tests_passed, tests_run, errors);
        if (errors == 0 && !aborted) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/cpu_pkg.sv
logic/inst_buffer.sv
logic/map_table.sv
logic/free_list.sv
logic/rob.sv
logic/cpu.sv
tests/cpu_checker.sv
tests/cpu_tb.sv

// File: Bender.yml
package:
  name: rename_front_end

export_include_dirs:
  - logic

sources:
  - logic/cpu_pkg.sv
  - logic/inst_buffer.sv
  - logic/map_table.sv
  - logic/free_list.sv
  - logic/rob.sv
  - logic/cpu.sv
  - target: test
    files:
      - tests/cpu_checker.sv
      - tests/cpu_tb.sv
